// File: rtl/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

    // Channel bank
    localparam int NUM_CH = 4;
    localparam int CH_W   = $clog2(NUM_CH);   // Channel select width
    localparam int DUTY_W = 8;                // Duty and carrier width

    // UART bit timing, short for simulation
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_CNT_W-1:0] BIT_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_W-1:0] BIT_MID  = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // Response bytes
    localparam logic [7:0] RSP_ACK = 8'h3C;
    localparam logic [7:0] RSP_NAK = 8'hC3;

    // Upper nibble of the opcode byte
    typedef enum logic [3:0] {
        OP_SET_DUTY = 4'h1,   // Low nibble channel, arg is duty
        OP_GET_DUTY = 4'h2,   // Arg ignored
        OP_SYNC     = 4'h9    // Whole bank restart
    } pwm_op_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_ARG,
        APB_SETUP,
        APB_ACCESS,
        RESPOND
    } dec_state_e;

endpackage

`default_nettype wire

// File: rtl/apb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// One register per channel, so no paddr
interface apb_bus_if;
    import pwm_pkg::*;

    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DUTY_W-1:0] pwdata;
    logic [DUTY_W-1:0] prdata;   // Shadow duty readback
    logic              pready;

    // Decoder side
    modport master (
        output psel,
        output penable,
        output pwrite,
        output pwdata,
        input  prdata,
        input  pready
    );

    // Channel side
    modport slave (
        input  psel,
        input  penable,
        input  pwrite,
        input  pwdata,
        output prdata,
        output pready
    );

endinterface

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       rx,
    output logic [7:0]      rx_data,
    output logic            rx_valid
);
    import pwm_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [BAUD_CNT_W-1:0] clk_cnt;
    logic [2:0]            bit_cnt;   // Data bit index

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;   // Single-cycle pulse
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= RX_START;   // Falling edge seen
                end
                RX_START: begin
                    if (clk_cnt == BIT_MID) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        // Still low at mid-bit, else a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == BIT_LAST) begin
                        rx_valid <= rx_sync;   // Low stop bit drops the frame
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data shifter, LSB first, sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == BIT_LAST) rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic [7:0] tx_data,
    input  wire logic       tx_start,
    output logic            tx,
    output logic            tx_busy
);
    import pwm_pkg::*;

    logic [9:0]            shreg;     // Stop, data, start
    logic [BAUD_CNT_W-1:0] clk_cnt;
    logic [3:0]            bit_cnt;   // Bits already sent

    assign tx = shreg[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg   <= '1;   // Line idles high
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (tx_start && !tx_busy) begin
            shreg   <= {1'b1, tx_data, 1'b0};
            tx_busy <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (tx_busy) begin
            if (clk_cnt == BIT_LAST) begin
                clk_cnt <= '0;
                shreg   <= {1'b1, shreg[9:1]};   // Backfill with idle level
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;   // Stop bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Decoder holds off while a byte is on the line
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n) tx_start |-> !tx_busy
    ) else $error("tx_start while uart_tx busy");

endmodule

`default_nettype wire

// File: rtl/pwm_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_cmd_decoder (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic [7:0] rx_data,
    input  wire logic       rx_valid,
    input  wire logic       tx_busy,
    output logic [7:0]      tx_data,
    output logic            tx_start,
    output logic            sync,
    apb_bus_if.master       apb [pwm_pkg::NUM_CH]
);
    import pwm_pkg::*;

    dec_state_e                    state;
    logic [7:0]                    cmd_q;   // Opcode byte
    logic [7:0]                    arg_q;   // Argument byte
    logic [7:0]                    rsp_q;   // Byte to send back
    pwm_op_e                       op;
    logic                          ch_ok;
    logic                          apb_ok;
    logic [CH_W-1:0]               ch_sel;
    logic                          in_xfer;
    logic [NUM_CH-1:0]             psel_v;
    logic [NUM_CH-1:0]             pready_v;
    logic [NUM_CH-1:0][DUTY_W-1:0] prdata_v;

    assign op      = pwm_op_e'(cmd_q[7:4]);
    assign ch_ok   = cmd_q[3:0] < 4'(NUM_CH);   // Full nibble, not just CH_W bits
    assign ch_sel  = cmd_q[CH_W-1:0];
    assign apb_ok  = (op == OP_SET_DUTY || op == OP_GET_DUTY) && ch_ok;
    assign in_xfer = (state == APB_SETUP) || (state == APB_ACCESS);

    // Response launch, held off by a busy transmitter
    assign tx_data  = rsp_q;
    assign tx_start = (state == RESPOND) && !tx_busy;
    assign sync     = tx_start && (op == OP_SYNC);

    for (genvar k = 0; k < NUM_CH; k++) begin : g_bus
        assign psel_v[k]      = in_xfer && (ch_sel == CH_W'(k));
        assign apb[k].psel    = psel_v[k];
        assign apb[k].penable = psel_v[k] && (state == APB_ACCESS);
        assign apb[k].pwrite  = (op == OP_SET_DUTY);
        assign apb[k].pwdata  = arg_q;
        assign pready_v[k]    = apb[k].pready;
        assign prdata_v[k]    = apb[k].prdata;   // Flattened for the read mux
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:       if (rx_valid) state <= WAIT_ARG;
                WAIT_ARG:   if (rx_valid) state <= apb_ok ? APB_SETUP : RESPOND;
                APB_SETUP:  state <= APB_ACCESS;
                APB_ACCESS: if (pready_v[ch_sel]) state <= RESPOND;
                RESPOND:    if (!tx_busy) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // Frame bytes and response
    always_ff @(posedge clk) begin
        if (state == IDLE && rx_valid) cmd_q <= rx_data;
        if (state == WAIT_ARG && rx_valid) begin
            arg_q <= rx_data;
            rsp_q <= (apb_ok || op == OP_SYNC) ? RSP_ACK : RSP_NAK;
        end
        // GET answers with the readback instead of ack
        if (state == APB_ACCESS && pready_v[ch_sel] && op == OP_GET_DUTY) begin
            rsp_q <= prdata_v[ch_sel];
        end
    end

    // Single select, only for a latched command that is a valid transfer
    a_one_psel: assert property (
        @(posedge clk) disable iff (!arst_n) in_xfer |-> apb_ok && $onehot(psel_v)
    ) else $error("psel raised for a bad command or more than one channel");

endmodule

`default_nettype wire

// File: rtl/pwm_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_channel (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic sync,
    apb_bus_if.slave  apb,
    output logic      pwm_out
);
    import pwm_pkg::*;

    logic [DUTY_W-1:0] shadow_duty;   // APB visible
    logic [DUTY_W-1:0] active_duty;   // Used by the comparator
    logic [DUTY_W-1:0] carrier;
    logic              wrap;

    assign apb.pready = 1'b1;   // Zero wait states
    assign apb.prdata = shadow_duty;

    assign wrap    = (carrier == '1);
    assign pwm_out = (carrier < active_duty);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow_duty <= '0;
        end else if (apb.psel && apb.penable && apb.pwrite) begin
            shadow_duty <= apb.pwdata;
        end
    end

    // Free-running carrier, restarted by the bank sync
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carrier <= '0;
        end else if (sync) begin
            carrier <= '0;
        end else begin
            carrier <= carrier + 1'b1;
        end
    end

    // New duty only at a period boundary, no runt pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_duty <= '0;
        end else if (wrap || sync) begin
            active_duty <= shadow_duty;
        end
    end

    a_enable_has_sel: assert property (
        @(posedge clk) disable iff (!arst_n) apb.penable |-> apb.psel
    ) else $error("penable without psel");

endmodule

`default_nettype wire

// File: rtl/pwm_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_link_top (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    rx,
    output logic                         tx,
    output logic                         sync_out,
    output logic [pwm_pkg::NUM_CH-1:0]   pwm_out
);
    import pwm_pkg::*;

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    apb_bus_if apb_bus [NUM_CH] ();   // One bus per channel

    uart_rx uart_rx_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    pwm_cmd_decoder pwm_cmd_decoder_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .sync     (sync_out),   // Also fans out to the bank
        .apb      (apb_bus)
    );

    for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
        pwm_channel pwm_channel_i (
            .clk     (clk),
            .arst_n  (arst_n),
            .sync    (sync_out),
            .apb     (apb_bus[k]),
            .pwm_out (pwm_out[k])
        );
    end

    uart_tx uart_tx_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// File: sim/pwm_link_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_link_checker (
    input  wire logic                                           clk,
    input  wire logic                                           arst_n,
    input  wire logic                                           tx,
    input  wire logic                                           sync_out,
    input  wire logic [pwm_pkg::NUM_CH-1:0]                     pwm_out,
    input  wire logic                                           idle_chk,   // Quiet window
    input  wire logic                                           exp_push,
    input  wire logic [7:0]                                     exp_byte,
    input  wire logic                                           meas_start,
    input  wire logic [pwm_pkg::NUM_CH-1:0][pwm_pkg::DUTY_W-1:0] exp_duty,
    input  wire logic [7:0]                                     exp_syncs,
    input  wire logic [3:0]                                     test_id,
    output int                                                  rsp_cnt,    // Bytes decoded
    output int                                                  meas_cnt,   // Windows done
    output int                                                  err_cnt
);
    import pwm_pkg::*;

    logic [7:0] exp_q [$];   // Model responses, oldest first
    logic [7:0] rx_byte;
    logic       idle_seen;
    int         rsp_err;
    int         meas_err;
    int         idle_err;
    int         sync_cnt;

    assign err_cnt = rsp_err + meas_err + idle_err;

    function automatic string test_label(input logic [3:0] id);
        case (id)
            4'd1:    return "reset_idle";
            4'd2:    return "set_get";
            4'd3:    return "sync_duty";
            4'd4:    return "bad_channel";
            4'd5:    return "bad_opcode";
            4'd6:    return "random_frames";
            default: return "unknown";
        endcase
    endfunction

    initial idle_seen = 1'b0;

    always @(posedge clk) if (exp_push) exp_q.push_back(exp_byte);

    always @(posedge clk) if (arst_n && sync_out) sync_cnt++;   // One per SYNC frame

    // Line and outputs must stay quiet with no input
    always @(posedge clk) begin
        if (idle_chk && !idle_seen && (tx !== 1'b1 || pwm_out !== '0)) begin
            $display("ERROR %s: tx or pwm_out left its idle level", test_label(test_id));
            idle_err++;
            idle_seen = 1'b1;   // Report once
        end
    end

    // 8N1 decoder on tx, sampled at mid-bit
    always begin : rsp_decode
        logic [7:0] want;
        @(posedge clk);
        if (arst_n && tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk);   // Middle of start bit
            if (tx !== 1'b0) begin
                $display("ERROR %s: start bit on tx ended early", test_label(test_id));
                rsp_err++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    rx_byte[i] = tx;   // LSB first
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                if (tx !== 1'b1) begin
                    $display("ERROR %s: stop bit on tx was low", test_label(test_id));
                    rsp_err++;
                end
                if (exp_q.size() == 0) begin
                    $display("ERROR %s: response 8'h%02h arrived with nothing expected",
                             test_label(test_id), rx_byte);
                    rsp_err++;
                end else begin
                    want = exp_q.pop_front();
                    if (want !== rx_byte) begin
                        $display("FAILED %s: expected 8'h%02h, actual 8'h%02h",
                                 test_label(test_id), want, rx_byte);
                        rsp_err++;
                    end
                end
                rsp_cnt++;
            end
        end
    end

    // High-cycle count per channel over one carrier period
    always begin : duty_measure
        logic [NUM_CH-1:0][DUTY_W-1:0] win_duty;
        int                            hi [NUM_CH];
        @(posedge clk);
        if (meas_start) begin
            win_duty = exp_duty;
            for (int k = 0; k < NUM_CH; k++) hi[k] = 0;
            repeat (1 << DUTY_W) begin
                @(posedge clk);
                for (int k = 0; k < NUM_CH; k++) if (pwm_out[k] === 1'b1) hi[k]++;
            end
            for (int k = 0; k < NUM_CH; k++) begin
                if (hi[k] != int'(win_duty[k])) begin
                    $display("FAILED %s: pwm_out[%0d] high cycles expected %0d, actual %0d",
                             test_label(test_id), k, win_duty[k], hi[k]);
                    meas_err++;
                end
            end
            if (sync_cnt != int'(exp_syncs)) begin
                $display("FAILED %s: sync_out pulses expected %0d, actual %0d",
                         test_label(test_id), exp_syncs, sync_cnt);
                meas_err++;
            end
            meas_cnt++;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_pwm_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_link;
    import pwm_pkg::*;

    localparam int N_FRAMES  = 64;   // Upper bound on frames sent
    localparam int N_WINDOWS = 2;    // Duty measurements
    localparam int WATCHDOG_CYCLES = N_FRAMES * 40 * CLKS_PER_BIT + N_WINDOWS * 600 + 2000;

    logic                          clk;
    logic                          arst_n;
    logic                          rx;
    logic                          tx;
    logic                          sync_out;
    logic [NUM_CH-1:0]             pwm_out;
    logic                          idle_chk;
    logic                          exp_push;
    logic [7:0]                    exp_byte;
    logic                          meas_start;
    logic [7:0]                    exp_syncs;    // SYNC frames so far
    logic [3:0]                    test_id;
    logic [NUM_CH-1:0][DUTY_W-1:0] model_duty;   // Shadow duty per channel
    int                            rsp_cnt;
    int                            meas_cnt;
    int                            err_cnt;
    integer                        seed;
    int                            tests_run;
    int                            tests_failed;
    int                            err_at_start;

    pwm_link_top pwm_link_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .tx       (tx),
        .sync_out (sync_out),
        .pwm_out  (pwm_out)
    );

    pwm_link_checker pwm_link_checker_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .tx         (tx),
        .sync_out   (sync_out),
        .pwm_out    (pwm_out),
        .idle_chk   (idle_chk),
        .exp_push   (exp_push),
        .exp_byte   (exp_byte),
        .meas_start (meas_start),
        .exp_duty   (model_duty),
        .exp_syncs  (exp_syncs),
        .test_id    (test_id),
        .rsp_cnt    (rsp_cnt),
        .meas_cnt   (meas_cnt),
        .err_cnt    (err_cnt)
    );

    always #4 clk = ~clk;   // 8 ns

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // 8N1 on rx, one bit per CLKS_PER_BIT
    task automatic send_byte(input logic [7:0] b);
        rx <= 1'b0;
        repeat (CLKS_PER_BIT) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            rx <= b[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        rx <= 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    // Model step, then frame out, then wait for the answer
    task automatic run_frame(input logic [7:0] cmd, input logic [7:0] arg);
        logic [7:0] rsp;
        int         target;
        if (cmd[7:4] == OP_SYNC) begin
            rsp = RSP_ACK;   // Channel nibble ignored
            exp_syncs <= exp_syncs + 1'b1;
        end else if ((cmd[7:4] == OP_SET_DUTY || cmd[7:4] == OP_GET_DUTY)
                     && cmd[3:0] < NUM_CH) begin
            if (cmd[7:4] == OP_SET_DUTY) begin
                rsp = RSP_ACK;
                model_duty[cmd[CH_W-1:0]] <= arg;
            end else begin
                rsp = model_duty[cmd[CH_W-1:0]];
            end
        end else begin
            rsp = RSP_NAK;   // Bad channel or opcode
        end
        exp_byte <= rsp;
        exp_push <= 1'b1;
        @(posedge clk);
        exp_push <= 1'b0;
        target = rsp_cnt + 1;
        send_byte(cmd);
        send_byte(arg);
        while (rsp_cnt < target) @(posedge clk);   // Host waits, no back-pressure
    endtask

    task automatic random_frame();
        logic [31:0] r;
        logic [3:0]  op;
        r = $random(seed);
        case (r[1:0])
            2'd0:    op = OP_SET_DUTY;
            2'd1:    op = OP_GET_DUTY;
            2'd2:    op = OP_SYNC;
            default: op = (r[3:2] == 2'd0) ? 4'h0 : (r[3:2] == 2'd1) ? 4'h3 :
                          (r[3:2] == 2'd2) ? 4'h7 : 4'hF;   // Not a valid opcode
        endcase
        run_frame({op, 1'b0, r[10:8]}, r[23:16]);   // Channels 0..7
    endtask

    task automatic measure_duty();
        int target;
        target = meas_cnt + 1;
        meas_start <= 1'b1;
        @(posedge clk);
        meas_start <= 1'b0;
        while (meas_cnt < target) @(posedge clk);
    endtask

    task automatic start_test(input logic [3:0] id);
        test_id <= id;
        err_at_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);   // Checker counts from the last edge have settled
        tests_run++;
        if (err_cnt != err_at_start) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, err_cnt - err_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        rx         = 1'b1;   // Line idle
        idle_chk   = 1'b0;
        exp_push   = 1'b0;
        exp_byte   = '0;
        meas_start = 1'b0;
        exp_syncs  = '0;
        test_id    = '0;
        model_duty = '0;
        seed       = 32'h26ea_b84f;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        start_test(4'd1);
        idle_chk <= 1'b1;
        repeat (200) @(posedge clk);
        idle_chk <= 1'b0;
        end_test("reset_idle");

        start_test(4'd2);
        for (int k = 0; k < NUM_CH; k++) run_frame({OP_SET_DUTY, 4'(k)}, 8'($random(seed)));
        for (int k = 0; k < NUM_CH; k++) run_frame({OP_GET_DUTY, 4'(k)}, 8'h00);
        end_test("set_get");

        start_test(4'd3);
        run_frame({OP_SYNC, 4'h0}, 8'h00);
        measure_duty();
        end_test("sync_duty");

        start_test(4'd4);
        run_frame({OP_SET_DUTY, 4'h4}, 8'($random(seed)));   // First index past the bank
        run_frame({OP_SET_DUTY, 4'hF}, 8'($random(seed)));
        run_frame({OP_GET_DUTY, 4'h9}, 8'h00);
        for (int k = 0; k < NUM_CH; k++) run_frame({OP_GET_DUTY, 4'(k)}, 8'h00);
        end_test("bad_channel");

        start_test(4'd5);
        run_frame({4'h0, 4'h1}, 8'h55);
        run_frame({4'hA, 4'h2}, 8'hAA);
        end_test("bad_opcode");

        start_test(4'd6);
        repeat (40) random_frame();
        run_frame({OP_SYNC, 4'h3}, 8'h00);   // Load every shadow before measuring
        measure_duty();
        end_test("random_frames");

        repeat (10) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d, responses %0d",
                 tests_run, tests_failed, err_cnt, rsp_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/pwm_pkg.sv
rtl/apb_bus_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/pwm_cmd_decoder.sv
rtl/pwm_channel.sv
rtl/pwm_link_top.sv
sim/pwm_link_checker.sv
sim/tb_pwm_link.sv

// File: Bender.yml
package:
  name: pwm_link

sources:
  - rtl/pwm_pkg.sv
  - rtl/apb_bus_if.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/pwm_cmd_decoder.sv
  - rtl/pwm_channel.sv
  - rtl/pwm_link_top.sv
  - target: test
    files:
      - sim/pwm_link_checker.sv
      - sim/tb_pwm_link.sv
